//--- hw/pkt_buf_defines.svh
`ifndef PKT_BUF_DEFINES_SVH
`define PKT_BUF_DEFINES_SVH

//////////////////////////////
// Packet buffer sizing
//////////////////////////////

// Width of one packet word
`define PKT_BUF_DATA_WIDTH 16

// Data FIFO entries
// Not a power of two on purpose
`define PKT_BUF_DATA_DEPTH 30

// Descriptor FIFO entries
`define PKT_BUF_DESC_DEPTH 4

// Longest legal packet in words
`define PKT_BUF_MAX_PKT 8

`endif

//--- hw/pkt_buf_pkg.sv
`include "pkt_buf_defines.svh"

package pkt_buf_pkg;

    //////////////////////////////
    // Payload types
    //////////////////////////////

    // One word of packet payload
    typedef logic [`PKT_BUF_DATA_WIDTH-1:0] data_word_t;

    // Packet length in words
    // Holds 1 through the maximum packet length
    typedef logic [$clog2(`PKT_BUF_MAX_PKT + 1)-1:0] pkt_len_t;

    //////////////////////////////
    // Descriptor
    //////////////////////////////

    // Entry of the descriptor FIFO
    // Written once per admitted packet at its last word
    typedef struct packed {
        pkt_len_t len;
    } pkt_desc_t;

endpackage

//--- hw/pkt_buf_top.sv
`include "pkt_buf_defines.svh"

module pkt_buf_top (
    input  logic                    wr_clk,
    input  logic                    reset,
    // Input stream
    input  logic                    in_valid,
    input  pkt_buf_pkg::data_word_t in_data,
    input  logic                    in_last,
    // Dropped packet strobe
    output logic                    drop,
    // Output stream
    input  logic                    out_hold,
    output logic                    out_valid,
    output pkt_buf_pkg::data_word_t out_data,
    output logic                    out_last
);

    import pkt_buf_pkg::*;

    // Ingress to data FIFO
    logic                                      data_wr;
    data_word_t                                data_wr_data;
    logic [$clog2(`PKT_BUF_DATA_DEPTH + 1)-1:0] data_free;

    // Ingress to descriptor FIFO
    logic                                      desc_wr;
    pkt_desc_t                                 desc_wr_data;
    logic                                      desc_full;

    // FIFOs to egress
    logic                                      data_rd;
    data_word_t                                data_rd_data;
    logic                                      desc_rd;
    pkt_desc_t                                 desc_rd_data;
    logic                                      desc_empty;

    //////////////////////////////
    // Ingress
    //////////////////////////////

    pkt_ingress u_ingress (
        .wr_clk       (wr_clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_last      (in_last),
        .data_free    (data_free),
        .desc_full    (desc_full),
        .data_wr      (data_wr),
        .data_wr_data (data_wr_data),
        .desc_wr      (desc_wr),
        .desc_wr_data (desc_wr_data),
        .drop         (drop)
    );

    //////////////////////////////
    // Storage
    //////////////////////////////

    // Packet words
    sync_fifo #(
        .payload_t (data_word_t),
        .DEPTH     (`PKT_BUF_DATA_DEPTH)
    ) u_data_fifo (
        .wr_clk  (wr_clk),
        .reset   (reset),
        .wr      (data_wr),
        .wr_data (data_wr_data),
        .full    (),
        .rd      (data_rd),
        .rd_data (data_rd_data),
        .empty   (),
        .free    (data_free)
    );

    // Packet lengths
    sync_fifo #(
        .payload_t (pkt_desc_t),
        .DEPTH     (`PKT_BUF_DESC_DEPTH)
    ) u_desc_fifo (
        .wr_clk  (wr_clk),
        .reset   (reset),
        .wr      (desc_wr),
        .wr_data (desc_wr_data),
        .full    (desc_full),
        .rd      (desc_rd),
        .rd_data (desc_rd_data),
        .empty   (desc_empty),
        .free    ()
    );

    //////////////////////////////
    // Egress
    //////////////////////////////

    pkt_egress u_egress (
        .wr_clk       (wr_clk),
        .reset        (reset),
        .out_hold     (out_hold),
        .desc_empty   (desc_empty),
        .desc_rd_data (desc_rd_data),
        .desc_rd      (desc_rd),
        .data_rd_data (data_rd_data),
        .data_rd      (data_rd),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_last     (out_last)
    );

endmodule

//--- hw/pkt_egress.sv
module pkt_egress (
    input  logic                    wr_clk,
    input  logic                    reset,
    // Hold off new packets
    input  logic                    out_hold,
    // Descriptor FIFO read side
    input  logic                    desc_empty,
    input  pkt_buf_pkg::pkt_desc_t  desc_rd_data,
    output logic                    desc_rd,
    // Data FIFO read side
    input  pkt_buf_pkg::data_word_t data_rd_data,
    output logic                    data_rd,
    // Outgoing word strobe
    output logic                    out_valid,
    output pkt_buf_pkg::data_word_t out_data,
    output logic                    out_last
);

    import pkt_buf_pkg::*;

    // Words still to pop for the current packet
    pkt_len_t remain;
    pkt_len_t remain_next;

    // Counter status
    logic busy;
    logic finishing;

    //////////////////////////////
    // Counter status
    //////////////////////////////

    // A nonzero count means a packet is streaming
    assign busy = (remain != '0);

    // Final word of the packet pops this cycle
    assign finishing = (remain == pkt_len_t'(1));

    //////////////////////////////
    // FIFO pops
    //////////////////////////////

    // Next descriptor may be taken while the last word pops
    // Back-to-back packets then stream with no gap
    // Hold only blocks the start of a packet
    assign desc_rd = (!busy || finishing) && !out_hold && !desc_empty;

    // One data word per counted cycle
    assign data_rd = busy;

    //////////////////////////////
    // Down-counter
    //////////////////////////////

    always_comb begin
        if (desc_rd) begin
            // Load the new length
            remain_next = desc_rd_data.len;
        end else if (busy) begin
            remain_next = remain - pkt_len_t'(1);
        end else begin
            remain_next = '0;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (reset) begin
            remain <= '0;
        end else begin
            remain <= remain_next;
        end
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    // Control strobes of the output stream
    always_ff @(posedge wr_clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= data_rd;
            // Marks the final popped word of the packet
            out_last  <= finishing;
        end
    end

    // Payload register
    // Only loads when a word is popped
    always_ff @(posedge wr_clk) begin
        if (data_rd) begin
            out_data <= data_rd_data;
        end
    end

endmodule

//--- hw/pkt_ingress.sv
`include "pkt_buf_defines.svh"

module pkt_ingress (
    input  logic                                   wr_clk,
    input  logic                                   reset,
    // Incoming word strobe
    input  logic                                   in_valid,
    input  pkt_buf_pkg::data_word_t                in_data,
    input  logic                                   in_last,
    // FIFO status
    input  logic [$clog2(`PKT_BUF_DATA_DEPTH + 1)-1:0] data_free,
    input  logic                                   desc_full,
    // Data FIFO write
    output logic                                   data_wr,
    output pkt_buf_pkg::data_word_t                data_wr_data,
    // Descriptor FIFO write
    output logic                                   desc_wr,
    output pkt_buf_pkg::pkt_desc_t                 desc_wr_data,
    // Dropped packet report
    output logic                                   drop
);

    import pkt_buf_pkg::*;

    // Room needed for one packet of maximum size
    localparam logic [$clog2(`PKT_BUF_DATA_DEPTH + 1)-1:0] MAX_WORDS =
        $bits(data_free)'(`PKT_BUF_MAX_PKT);

    // Packet tracking
    logic     in_pkt;
    logic     admit_q;
    pkt_len_t len_cnt;

    // Decisions for the current word
    logic     admit_now;
    logic     cur_admit;
    pkt_len_t word_num;

    // Registered drop strobe
    logic     drop_q;

    //////////////////////////////
    // Admission
    //////////////////////////////

    always_comb begin
        // Evaluated only on the first word of a packet
        admit_now = (data_free >= MAX_WORDS) && !desc_full;
        // Later words follow the decision held from the first one
        cur_admit = in_pkt ? admit_q : admit_now;
        // Position of this word within its packet
        word_num  = in_pkt ? (len_cnt + pkt_len_t'(1)) : pkt_len_t'(1);
    end

    //////////////////////////////
    // FIFO writes
    //////////////////////////////

    // Words go into the data FIFO in the cycle they arrive
    assign data_wr      = in_valid && cur_admit;
    assign data_wr_data = in_data;

    // Descriptor goes in with the last word
    assign desc_wr = in_valid && in_last && cur_admit;

    always_comb begin
        desc_wr_data     = '0;
        desc_wr_data.len = word_num;
    end

    //////////////////////////////
    // Packet state
    //////////////////////////////

    always_ff @(posedge wr_clk) begin
        if (reset) begin
            in_pkt  <= 1'b0;
            admit_q <= 1'b0;
            len_cnt <= '0;
        end else if (in_valid) begin
            // Last word returns to the between-packets state
            in_pkt  <= !in_last;
            admit_q <= cur_admit;
            len_cnt <= in_last ? pkt_len_t'(0) : word_num;
        end
    end

    // Drop shows one cycle after a rejected last word
    always_ff @(posedge wr_clk) begin
        if (reset) begin
            drop_q <= 1'b0;
        end else begin
            drop_q <= in_valid && in_last && !cur_admit;
        end
    end

    assign drop = drop_q;

endmodule

//--- hw/sync_fifo.sv
module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic                         wr_clk,
    input  logic                         reset,
    // Write side
    input  logic                         wr,
    input  payload_t                     wr_data,
    output logic                         full,
    // Read side
    input  logic                         rd,
    output payload_t                     rd_data,
    output logic                         empty,
    // Free entries left
    output logic [$clog2(DEPTH + 1)-1:0] free
);

    // Pointer width
    // One bit minimum so a single entry FIFO still builds
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // Occupancy width
    // Must hold the value DEPTH itself
    localparam int CW = $clog2(DEPTH + 1);

    // Last valid pointer value before the wrap
    localparam logic [AW-1:0] LAST_ADDR = AW'(DEPTH - 1);

    // Occupancy value when every entry is used
    localparam logic [CW-1:0] FULL_COUNT = CW'(DEPTH);

    // Flop storage
    payload_t mem [DEPTH];

    // Pointers into the storage
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;

    // Registered occupancy
    logic [CW-1:0] count;

    // Accepted operations
    logic push;
    logic pop;

    //////////////////////////////
    // Accept logic
    //////////////////////////////

    // Write into a full FIFO is ignored
    assign push = wr && !full;

    // Read from an empty FIFO is ignored
    assign pop = rd && !empty;

    //////////////////////////////
    // Write pointer
    //////////////////////////////

    // Wraps at DEPTH rather than at a power of two
    always_ff @(posedge wr_clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (push) begin
            if (wr_ptr == LAST_ADDR) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + AW'(1);
            end
        end
    end

    // Store the word at the write pointer
    always_ff @(posedge wr_clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    //////////////////////////////
    // Read pointer
    //////////////////////////////

    // Same wrap rule as the write side
    always_ff @(posedge wr_clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (pop) begin
            if (rd_ptr == LAST_ADDR) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + AW'(1);
            end
        end
    end

    // Fall-through read
    // Head entry shows before the pop
    assign rd_data = mem[rd_ptr];

    //////////////////////////////
    // Occupancy
    //////////////////////////////

    // Push and pop together leave the count alone
    always_ff @(posedge wr_clk) begin
        if (reset) begin
            count <= '0;
        end else if (push && !pop) begin
            count <= count + CW'(1);
        end else if (pop && !push) begin
            count <= count - CW'(1);
        end
    end

    // Flags all come from the registered count
    assign full  = (count == FULL_COUNT);
    assign empty = (count == '0);
    assign free  = FULL_COUNT - count;

endmodule

//--- pkt_buf.f
+incdir+hw
hw/pkt_buf_pkg.sv
hw/sync_fifo.sv
hw/pkt_ingress.sv
hw/pkt_egress.sv
hw/pkt_buf_top.sv
verif/pkt_buf_checker.sv
verif/pkt_buf_tb.sv

//--- verif/pkt_buf_cases.txt
// Columns, all hex: gap hold len w0 w1 w2 w3 w4 w5 w6 w7 drop
// Unused words are 0000, a record with len 0 ends the list
// Single packets, hold low
04 0 1 0101 0000 0000 0000 0000 0000 0000 0000 0
06 0 3 0201 0202 0203 0000 0000 0000 0000 0000 0
0a 0 8 a5a5 5a5a ffff 0000 1234 8001 7ffe c3c3 0
0c 0 5 0401 0402 0403 0404 0405 0000 0000 0000 0
// Back to back, lengths 1 to 8
0c 0 1 0501 0000 0000 0000 0000 0000 0000 0000 0
00 0 2 0601 0602 0000 0000 0000 0000 0000 0000 0
00 0 3 0701 0702 0703 0000 0000 0000 0000 0000 0
00 0 4 0801 0802 0803 0804 0000 0000 0000 0000 0
00 0 5 0901 0902 0903 0904 0905 0000 0000 0000 0
00 0 6 0a01 0a02 0a03 0a04 0a05 0a06 0000 0000 0
00 0 7 0b01 0b02 0b03 0b04 0b05 0b06 0b07 0000 0
00 0 8 0c01 0c02 0c03 0c04 0c05 0c06 0c07 0c08 0
// Fill under hold, previous packet stays stored, data room runs out
14 0 8 0d01 0d02 0d03 0d04 0d05 0d06 0d07 0d08 0
02 1 8 0e01 0e02 0e03 0e04 0e05 0e06 0e07 0e08 0
02 1 8 0f01 0f02 0f03 0f04 0f05 0f06 0f07 0f08 0
02 1 2 1001 1002 0000 0000 0000 0000 0000 0000 1
00 1 1 1101 0000 0000 0000 0000 0000 0000 0000 1
// Release, stored packets drain first
28 0 4 1201 1202 1203 1204 0000 0000 0000 0000 0
// Fill under hold, descriptors run out first
14 0 3 1301 1302 1303 0000 0000 0000 0000 0000 0
02 1 3 1401 1402 1403 0000 0000 0000 0000 0000 0
02 1 3 1501 1502 1503 0000 0000 0000 0000 0000 0
02 1 3 1601 1602 1603 0000 0000 0000 0000 0000 0
01 1 2 1701 1702 0000 0000 0000 0000 0000 0000 1
1e 0 6 1801 1802 1803 1804 1805 1806 0000 0000 0
// Extra traffic for data FIFO pointer wrap
00 0 8 1901 1902 1903 1904 1905 1906 1907 1908 0
00 0 8 f1e2 d3c4 b5a6 9788 796a 5b4c 3d2e 1f00 0
00 0 8 1b01 1b02 1b03 1b04 1b05 1b06 1b07 1b08 0
00 0 8 1c01 1c02 1c03 1c04 1c05 1c06 1c07 1c08 0
// End of list
00 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0

//--- verif/pkt_buf_checker.sv
`include "pkt_buf_defines.svh"

module pkt_buf_checker (
    input logic                                       wr_clk,
    input logic                                       reset,
    // Input stream
    input logic                                       in_valid,
    input logic                                       in_last,
    // Data FIFO traffic
    input logic                                       data_wr,
    input logic                                       data_rd,
    input logic [$clog2(`PKT_BUF_DATA_DEPTH + 1)-1:0] data_free,
    // Descriptor FIFO traffic
    input logic                                       desc_wr,
    input logic                                       desc_full,
    // Drop strobe
    input logic                                       drop
);

    timeunit 1ns;
    timeprecision 1ps;

    // Failed assertions so far
    int fail_count = 0;

    // Words seen so far in the current input packet
    logic [7:0] word_cnt;

    always_ff @(posedge wr_clk) begin
        if (reset) begin
            word_cnt <= '0;
        end else if (in_valid) begin
            word_cnt <= in_last ? 8'd0 : (word_cnt + 8'd1);
        end
    end

    //////////////////////////////
    // FIFO protocol
    //////////////////////////////

    // Data FIFO full means zero free entries
    a_data_no_overflow: assert property (@(posedge wr_clk) disable iff (reset)
        data_wr |-> (data_free != '0))
        else begin
            fail_count++;
            $error("data FIFO written while full");
        end

    // Data FIFO empty means every entry free
    a_data_no_underflow: assert property (@(posedge wr_clk) disable iff (reset)
        data_rd |-> (data_free != `PKT_BUF_DATA_DEPTH))
        else begin
            fail_count++;
            $error("data FIFO read while empty");
        end

    a_desc_no_overflow: assert property (@(posedge wr_clk) disable iff (reset)
        desc_wr |-> !desc_full)
        else begin
            fail_count++;
            $error("descriptor FIFO written while full");
        end

    //////////////////////////////
    // Packet protocol
    //////////////////////////////

    // A packet is either stored or dropped, never both
    a_drop_or_store: assert property (@(posedge wr_clk) disable iff (reset)
        !(drop && desc_wr))
        else begin
            fail_count++;
            $error("drop and descriptor write in the same cycle");
        end

    // Word about to arrive must still fit in a maximum packet
    a_pkt_max_len: assert property (@(posedge wr_clk) disable iff (reset)
        in_valid |-> (word_cnt < `PKT_BUF_MAX_PKT))
        else begin
            fail_count++;
            $error("input packet longer than the maximum");
        end

endmodule

// Attach to the top level; port names match its internal nets
bind pkt_buf_top pkt_buf_checker u_checker (.*);

//--- verif/pkt_buf_tb.sv
`include "pkt_buf_defines.svh"

module pkt_buf_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import pkt_buf_pkg::*;

    // Record layout is gap, hold, len, max-packet words and drop flag
    localparam int REC_FIELDS   = `PKT_BUF_MAX_PKT + 4;
    localparam int MAX_RECS     = 64;
    localparam int RESET_CYCLES = 10;

    // DUT ports
    logic       wr_clk;
    logic       reset;
    logic       in_valid;
    data_word_t in_data;
    logic       in_last;
    logic       drop;
    logic       out_hold;
    logic       out_valid;
    data_word_t out_data;
    logic       out_last;

    // Case file image
    logic [15:0] cases_mem [0:REC_FIELDS*MAX_RECS-1];

    // Words of admitted packets, in output order
    data_word_t exp_data_q[$];
    logic       exp_last_q[$];
    data_word_t exp_word;
    logic       exp_last;

    // Drop result owed by the last packet sent
    logic drop_pending;
    logic drop_expect;

    // Error counts
    int data_errs  = 0;
    int last_errs  = 0;
    int drop_errs  = 0;
    int other_errs = 0;

    // Timeout
    int cycle_count = 0;
    int cycle_limit = 0;
    int num_recs    = 0;

    pkt_buf_top dut (
        .wr_clk    (wr_clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_last   (in_last),
        .drop      (drop),
        .out_hold  (out_hold),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last)
    );

    // 4 ns clock
    initial begin
        wr_clk = 1'b0;
        forever #2 wr_clk = ~wr_clk;
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // Step to the next falling edge, settle any owed drop result
    task automatic next_cycle();
        @(negedge wr_clk);
        if (drop_pending) begin
            assert (drop == drop_expect) else begin
                drop_errs++;
                $display("error: drop expected %h got %h", drop_expect, drop);
            end
            drop_pending = 1'b0;
        end else begin
            // No packet ended last cycle so no strobe
            assert (drop == 1'b0) else begin
                drop_errs++;
                $display("error: drop expected %h got %h", 1'b0, drop);
            end
        end
    endtask

    // Idle gap, then one packet, with the record's hold level throughout
    task automatic run_record(input int rec);
        int   base;
        int   gap;
        int   len;
        logic hold;
        logic drop_flag;
        base      = rec * REC_FIELDS;
        gap       = int'(cases_mem[base]);
        hold      = cases_mem[base + 1][0];
        len       = int'(cases_mem[base + 2]);
        drop_flag = cases_mem[base + REC_FIELDS - 1][0];
        repeat (gap) begin
            next_cycle();
            out_hold = hold;
            in_valid = 1'b0;
            in_last  = 1'b0;
        end
        for (int i = 0; i < len; i++) begin
            next_cycle();
            out_hold = hold;
            in_valid = 1'b1;
            in_data  = cases_mem[base + 3 + i];
            in_last  = (i == len - 1);
            // Admitted packets come out whole and in order
            if (!drop_flag) begin
                exp_data_q.push_back(cases_mem[base + 3 + i]);
                exp_last_q.push_back(i == len - 1);
            end
        end
        drop_pending = 1'b1;
        drop_expect  = drop_flag;
    endtask

    //////////////////////////////
    // Output monitor
    //////////////////////////////

    // Outputs change on the rising edge and are stable here
    always @(negedge wr_clk) begin
        if (!reset && out_valid) begin
            assert (exp_data_q.size() != 0) else begin
                other_errs++;
                $display("output word %h came out with no stored packet left", out_data);
            end
            if (exp_data_q.size() != 0) begin
                exp_word = exp_data_q.pop_front();
                exp_last = exp_last_q.pop_front();
                assert (out_data == exp_word) else begin
                    data_errs++;
                    $display("error: out_data expected %h got %h", exp_word, out_data);
                end
                assert (out_last == exp_last) else begin
                    last_errs++;
                    $display("error: out_last expected %h got %h", exp_last, out_last);
                end
            end
        end else if (!reset) begin
            assert (out_last == 1'b0) else begin
                other_errs++;
                $display("out_last raised without out_valid");
            end
        end
    end

    // Run limit from the length of the case file
    always @(posedge wr_clk) begin
        if (!reset) begin
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                $display("timeout after %0d cycles with %0d output words still missing",
                         cycle_count, exp_data_q.size());
                $display(">>> FAIL");
                $finish;
            end
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int total;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_data      = '0;
        in_last      = 1'b0;
        out_hold     = 1'b0;
        drop_pending = 1'b0;
        drop_expect  = 1'b0;
        $readmemh("verif/pkt_buf_cases.txt", cases_mem);
        // A zero length record ends the list
        while (num_recs < MAX_RECS &&
               !$isunknown(cases_mem[num_recs * REC_FIELDS + 2]) &&
               cases_mem[num_recs * REC_FIELDS + 2] != 16'h0) begin
            cycle_limit += int'(cases_mem[num_recs * REC_FIELDS]);
            cycle_limit += int'(cases_mem[num_recs * REC_FIELDS + 2]) + 40;
            num_recs++;
        end
        assert (num_recs > 0) else begin
            other_errs++;
            $display("no packet records could be read from the case file");
        end
        repeat (RESET_CYCLES) @(negedge wr_clk);
        reset = 1'b0;
        for (int r = 0; r < num_recs; r++) begin
            run_record(r);
        end
        next_cycle();
        in_valid = 1'b0;
        in_last  = 1'b0;
        out_hold = 1'b0;
        // Wait for every admitted word to leave
        while (exp_data_q.size() != 0) begin
            next_cycle();
        end
        // A few idle cycles to catch stray words
        repeat (4) next_cycle();
        total = data_errs + last_errs + drop_errs + other_errs + dut.u_checker.fail_count;
        $display("summary: %0d data, %0d last, %0d drop, %0d other errors, %0d assertion fails",
                 data_errs, last_errs, drop_errs, other_errs, dut.u_checker.fail_count);
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
